//--- rtl/issuePkg.sv
package issuePkg;

    // instruction class, one per RV32I major opcode
    typedef enum logic [3:0] {
        opImm,
        opReg,
        opLoad,
        opStore,
        opBranch,
        opJal,
        opJalr,
        opLui,
        opAuipc,
        opIllegal
    } opClass_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluFn_t;

    // operand B source
    typedef enum logic [1:0] {
        selReg,
        selImm,
        selShamt
    } bSel_t;

    typedef struct packed {
        opClass_t    opClass;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        aluFn_t      aluFn;
        bSel_t       bSel;
        logic [2:0]  fn3;
        logic [3:0]  memOp;    // {isStore, fn3} for memory classes
        logic        we;
        logic        bneq;     // branch condition inverted (bne, bge, bgeu)
        logic        btype;
        logic        j;
        logic        jr;
        logic        lui;
        logic        auipc;
        logic [1:0]  pcSelect;
        logic [4:0]  shamt;
        logic [31:0] iImm;
        logic [31:0] bImm;
        logic [31:0] jImm;
        logic [31:0] sImm;
        logic [31:0] uImm;
        logic [31:0] pc;
    } decodedOp_t;

    // what pipe 4 hands to execute
    typedef struct packed {
        opClass_t    opClass;
        logic [4:0]  rd;
        aluFn_t      aluFn;
        bSel_t       bSel;
        logic [2:0]  fn3;
        logic [3:0]  memOp;
        logic        we;
        logic        bneq;
        logic        btype;
        logic        j;
        logic        jr;
        logic        lui;
        logic        auipc;
        logic [1:0]  pcSelect;
        logic [4:0]  shamt;
        logic [31:0] bImm;
        logic [31:0] jImm;
        logic [31:0] sImm;
        logic [31:0] uImm;
        logic [31:0] pc;
        logic [31:0] opA;
        logic [31:0] opB;
    } issuedOp_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbPort_t;

    // addi x0, x0, 0 used as the pipeline bubble
    localparam decodedOp_t NOP_OP = '{
        opClass:  opImm,
        rs1:      5'd0,
        rs2:      5'd0,
        rd:       5'd0,
        aluFn:    aluAdd,
        bSel:     selImm,
        fn3:      3'd0,
        memOp:    4'd0,
        we:       1'b1,
        bneq:     1'b0,
        btype:    1'b0,
        j:        1'b0,
        jr:       1'b0,
        lui:      1'b0,
        auipc:    1'b0,
        pcSelect: 2'd0,
        shamt:    5'd0,
        iImm:     32'd0,
        bImm:     32'd0,
        jImm:     32'd0,
        sImm:     32'd0,
        uImm:     32'd0,
        pc:       32'd0
    };

endpackage

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import issuePkg::*; (
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output decodedOp_t  dec
);

    logic [6:0] opcode;
    logic [2:0] fn3;
    logic       alt;    // instr[30] selects sub and sra
    opClass_t   cls;

    assign opcode = instr[6:0];
    assign fn3    = instr[14:12];
    assign alt    = instr[30];

    always_comb
    begin
        case (opcode)
            7'b0010011: cls = opImm;
            7'b0110011: cls = opReg;
            7'b0000011: cls = opLoad;
            7'b0100011: cls = opStore;
            7'b1100011: cls = opBranch;
            7'b1101111: cls = opJal;
            7'b1100111: cls = opJalr;
            7'b0110111: cls = opLui;
            7'b0010111: cls = opAuipc;
            default:    cls = opIllegal;
        endcase
    end

    always_comb
    begin
        dec         = '0;
        dec.opClass = cls;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.fn3     = fn3;
        dec.shamt   = instr[24:20];
        dec.pc      = pc;

        // sign extended immediates, all formats built every cycle
        dec.iImm = {{20{instr[31]}}, instr[31:20]};
        dec.sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        dec.bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        dec.uImm = {instr[31:12], 12'b0};

        // only the arithmetic classes take the alu function from fn3
        dec.aluFn = aluAdd;
        if (cls == opReg || cls == opImm)
        begin
            case (fn3)
                3'b000: dec.aluFn = (cls == opReg && alt) ? aluSub : aluAdd;
                3'b001: dec.aluFn = aluSll;
                3'b010: dec.aluFn = aluSlt;
                3'b011: dec.aluFn = aluSltu;
                3'b100: dec.aluFn = aluXor;
                3'b101: dec.aluFn = alt ? aluSra : aluSrl;
                3'b110: dec.aluFn = aluOr;
                default: dec.aluFn = aluAnd;
            endcase
        end

        if (cls == opReg)
            dec.bSel = selReg;
        else if (cls == opImm && fn3[1:0] == 2'b01)
            dec.bSel = selShamt;    // slli, srli, srai
        else
            dec.bSel = selImm;

        dec.we    = !(cls inside {opStore, opBranch, opIllegal});
        dec.btype = (cls == opBranch);
        dec.bneq  = (cls == opBranch) && fn3[0];
        dec.j     = (cls == opJal);
        dec.jr    = (cls == opJalr);
        dec.lui   = (cls == opLui);
        dec.auipc = (cls == opAuipc);

        // next pc source: 0 sequential, 1 branch, 2 jal, 3 jalr
        case (cls)
            opBranch: dec.pcSelect = 2'd1;
            opJal:    dec.pcSelect = 2'd2;
            opJalr:   dec.pcSelect = 2'd3;
            default:  dec.pcSelect = 2'd0;
        endcase

        if (cls == opLoad || cls == opStore)
            dec.memOp = {cls == opStore, fn3};
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile import issuePkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  wbPort_t     wb,
    output logic [31:0] rdA,
    output logic [31:0] rdB
);

    logic [31:0] regs [32];
    logic        wbValid;   // commit write that actually lands

    assign wbValid = wb.we && (wb.addr != 5'd0);

    // x0 reads zero, a write to the same register this cycle is forwarded
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (wbValid && wb.addr == addr)
            return wb.data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            rdA <= '0;
            rdB <= '0;
        end
        else
        begin
            if (wbValid)
                regs[wb.addr] <= wb.data;
            rdA <= readPort(rs1);
            rdB <= readPort(rs2);
        end
    end

endmodule

//--- rtl/hazardScoreboard.sv
`timescale 1ns/1ps

module hazardScoreboard import issuePkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  decodedOp_t dec,
    input  wbPort_t    wb,
    output logic       stall
);

    logic [31:0] pending;   // one bit per register with a write in flight
    logic [31:0] wbMask;
    logic [31:0] setMask;
    logic        readsRs1;
    logic        readsRs2;
    logic        busy1;
    logic        busy2;

    // register retiring this cycle, x0 never counts
    assign wbMask = (wb.we && wb.addr != 5'd0) ? (32'd1 << wb.addr) : '0;

    always_comb
    begin
        readsRs1 = dec.opClass inside {opImm, opReg, opLoad, opStore, opBranch, opJalr};
        readsRs2 = dec.opClass inside {opReg, opStore, opBranch};
    end

    // the regfile bypasses a write landing now, so it is not a hazard
    assign busy1 = pending[dec.rs1] && !wbMask[dec.rs1];
    assign busy2 = pending[dec.rs2] && !wbMask[dec.rs2];
    assign stall = (readsRs1 && busy1) || (readsRs2 && busy2);

    assign setMask = (!stall && dec.we && dec.rd != 5'd0) ? (32'd1 << dec.rd) : '0;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            pending <= '0;
        else
            pending <= (pending & ~wbMask) | setMask;   // set wins over clear
    end

endmodule

//--- rtl/issueStage.sv
`timescale 1ns/1ps

module issueStage import issuePkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  decodedOp_t dec,
    input  wbPort_t    wb,
    output issuedOp_t  issued,
    output logic       stall
);

    decodedOp_t  opQ;   // pipe 4
    logic [31:0] rdA;
    logic [31:0] rdB;

    regFile regs (
        .clk  (clk),
        .nrst (nrst),
        .rs1  (dec.rs1),
        .rs2  (dec.rs2),
        .wb   (wb),
        .rdA  (rdA),
        .rdB  (rdB)
    );

    hazardScoreboard scoreboard (
        .clk   (clk),
        .nrst  (nrst),
        .dec   (dec),
        .wb    (wb),
        .stall (stall)
    );

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            opQ <= '0;
        else if (stall)
            opQ <= NOP_OP;  // bubble, fetch holds the instruction
        else
            opQ <= dec;
    end

    always_comb
    begin
        issued.opClass  = opQ.opClass;
        issued.rd       = opQ.rd;
        issued.aluFn    = opQ.aluFn;
        issued.bSel     = opQ.bSel;
        issued.fn3      = opQ.fn3;
        issued.memOp    = opQ.memOp;
        issued.we       = opQ.we;
        issued.bneq     = opQ.bneq;
        issued.btype    = opQ.btype;
        issued.j        = opQ.j;
        issued.jr       = opQ.jr;
        issued.lui      = opQ.lui;
        issued.auipc    = opQ.auipc;
        issued.pcSelect = opQ.pcSelect;
        issued.shamt    = opQ.shamt;
        issued.bImm     = opQ.bImm;
        issued.jImm     = opQ.jImm;
        issued.sImm     = opQ.sImm;
        issued.uImm     = opQ.uImm;
        issued.pc       = opQ.pc;
        issued.opA      = rdA;

        case (opQ.bSel)
            selImm:   issued.opB = opQ.iImm;
            selShamt: issued.opB = {27'd0, opQ.shamt};
            default:  issued.opB = rdB;
        endcase
    end

endmodule

//--- rtl/issueTop.sv
`timescale 1ns/1ps

module issueTop import issuePkg::*; (
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  wbPort_t     wb,
    output issuedOp_t   issued,
    output logic        stall    // back to fetch, hold instr and pc
);

    decodedOp_t dec;

    instrDecoder decoder (
        .instr (instr),
        .pc    (pc),
        .dec   (dec)
    );

    issueStage stage (
        .clk    (clk),
        .nrst   (nrst),
        .dec    (dec),
        .wb     (wb),
        .issued (issued),
        .stall  (stall)
    );

endmodule

//--- sim/issueTb.sv
`timescale 1ns/1ps

module issueTb import issuePkg::*; ();

    localparam int NUM_RANDOM  = 300;
    localparam int NUM_INSTR   = NUM_RANDOM + 90;   // random part plus preload and directed
    localparam int WATCHDOG_NS = (NUM_INSTR + 200) * 20;
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    logic        clk;
    logic        nrst;
    logic [31:0] instr;
    logic [31:0] pc;
    wbPort_t     wb;
    issuedOp_t   issued;
    logic        stall;

    logic [31:0] refRegs [32];  // committed register state
    logic [31:0] pending;       // writes in flight, same rule as the scoreboard
    logic [31:0] curPc;
    issuedOp_t   expIssued;
    issuedOp_t   nextIssued;
    logic        expStall;
    logic        checkA;        // opA is don't care on a bubble
    logic        checkANext;
    int          errors;
    int          issuedCount;
    int          stallCount;
    string       testName;
    opClass_t    legalClass [9] = '{opImm, opReg, opLoad, opStore, opBranch,
                                    opJal, opJalr, opLui, opAuipc};
    opClass_t    consumer [3] = '{opReg, opStore, opBranch};
    opClass_t    quiet [4] = '{opLui, opJal, opAuipc, opImm};

    issueTop dut_i (
        .clk    (clk),
        .nrst   (nrst),
        .instr  (instr),
        .pc     (pc),
        .wb     (wb),
        .issued (issued),
        .stall  (stall)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic valueError(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        errors++;
        $display("Error: %s %s expected %h actual %h", testName, field, expected, actual);
    endtask

    // class, alu function, we and rd packed into one word for reporting
    function automatic logic [31:0] ctrlOf(input issuedOp_t op);
        return {18'd0, op.opClass, op.aluFn, op.we, op.rd};
    endfunction

    // operand select, fn3, memory op, branch and jump flags, pc select and shamt
    function automatic logic [31:0] flagsOf(input issuedOp_t op);
        return {10'd0, op.bSel, op.fn3, op.memOp, op.bneq, op.btype, op.j, op.jr, op.lui,
                op.auipc, op.pcSelect, op.shamt};
    endfunction

    function automatic aluFn_t expAlu(input opClass_t cls, input logic [31:0] ins);
        aluFn_t byFn3 [8];
        byFn3 = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
        if (!(cls inside {opImm, opReg}))
            return aluAdd;
        if (ins[14:12] == 3'd0 && cls == opReg && ins[30])
            return aluSub;
        if (ins[14:12] == 3'd5 && ins[30])
            return aluSra;
        return byFn3[ins[14:12]];
    endfunction

    // random legal RV32I word of the given class
    function automatic logic [31:0] makeInstr(input opClass_t cls);
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $urandom;
        f3 = r[14:12];
        case (cls)
            opImm:
            begin
                if (f3 == 3'd1)
                    r[31:25] = 7'd0;
                else if (f3 == 3'd5)
                    r[31:25] = {1'b0, r[30], 5'd0};   // srli or srai
                return {r[31:7], 7'b0010011};
            end
            opReg:    return {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, r[24:7], 7'b0110011};
            opLoad:   return {r[31:15], (f3 == 3'd3 || f3[2:1] == 2'b11) ? 3'd2 : f3, r[11:7],
                              7'b0000011};
            opStore:  return {r[31:15], 1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0], r[11:7],
                              7'b0100011};
            opBranch: return {r[31:15], (f3[2:1] == 2'b01) ? 3'd0 : f3, r[11:7], 7'b1100011};
            opJal:    return {r[31:7], 7'b1101111};
            opJalr:   return {r[31:15], 3'd0, r[11:7], 7'b1100111};
            opLui:    return {r[31:7], 7'b0110111};
            default:  return {r[31:7], 7'b0010111};
        endcase
    endfunction

    function automatic logic [31:0] withRegs(input logic [31:0] ins, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] r;
        r        = ins;
        r[11:7]  = rd;
        r[19:15] = rs1;
        r[24:20] = rs2;
        return r;
    endfunction

    // one fetch cycle: drive on the falling edge and predict what the next edges show
    task automatic stepCycle(input logic [31:0] ins, input opClass_t cls, input wbPort_t w);
        logic [31:0] wbMask;
        logic [31:0] live;
        logic        readA;
        logic        readB;
        issuedOp_t   e;
        @(negedge clk);
        nrst      = 1'b1;   // first call ends reset
        expIssued = nextIssued;
        checkA    = checkANext;
        instr     = ins;
        pc        = curPc;
        wb        = w;
        wbMask    = (w.we && w.addr != 5'd0) ? (32'd1 << w.addr) : 32'd0;
        if (wbMask != 32'd0)
            refRegs[w.addr] = w.data;
        live     = pending & ~wbMask;   // a landing write is bypassed
        readA    = cls inside {opImm, opReg, opLoad, opStore, opBranch, opJalr};
        readB    = cls inside {opReg, opStore, opBranch};
        expStall = (readA && live[ins[19:15]]) || (readB && live[ins[24:20]]);
        e        = '0;
        if (expStall)
        begin
            e.opClass = NOP_OP.opClass;
            e.aluFn   = NOP_OP.aluFn;
            e.we      = NOP_OP.we;
            e.rd      = NOP_OP.rd;
            e.bSel    = NOP_OP.bSel;
            e.opB     = NOP_OP.iImm;
            pending   = live;
            stallCount++;
        end
        else
        begin
            e.opClass = cls;
            e.aluFn   = expAlu(cls, ins);
            e.we      = !(cls inside {opStore, opBranch});
            e.rd      = ins[11:7];
            e.fn3     = ins[14:12];
            e.shamt   = ins[24:20];
            e.btype   = (cls == opBranch);
            e.bneq    = (cls == opBranch) && ins[12];   // bne, bge, bgeu
            e.j       = (cls == opJal);
            e.jr      = (cls == opJalr);
            e.lui     = (cls == opLui);
            e.auipc   = (cls == opAuipc);
            if (cls inside {opLoad, opStore})
                e.memOp = {cls == opStore, ins[14:12]};
            if (cls == opBranch)
                e.pcSelect = 2'd1;
            else if (cls == opJal)
                e.pcSelect = 2'd2;
            else if (cls == opJalr)
                e.pcSelect = 2'd3;
            e.bImm    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            e.jImm    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            e.sImm    = {{21{ins[31]}}, ins[30:25], ins[11:7]};
            e.uImm    = {ins[31:12], 12'd0};
            e.pc      = curPc;
            e.opA     = refRegs[ins[19:15]];
            if (cls == opReg)
            begin
                e.bSel = selReg;
                e.opB  = refRegs[ins[24:20]];
            end
            else if (cls == opImm && ins[14:12] inside {3'd1, 3'd5})
            begin
                e.bSel = selShamt;
                e.opB  = {27'd0, ins[24:20]};
            end
            else
            begin
                e.bSel = selImm;
                e.opB  = {{21{ins[31]}}, ins[30:20]};
            end
            pending = live | ((e.we && e.rd != 5'd0) ? (32'd1 << e.rd) : 32'd0);
            curPc   = curPc + 32'd4;
            issuedCount++;
        end
        nextIssued = e;
        checkANext = !expStall;
    endtask

    assert property (@(posedge clk) nrst || (issued == '0 && !stall))
        else valueError("reset state", 32'd0, 32'($sampled(issued.we)));
    assert property (@(posedge clk) disable iff (!nrst) stall == expStall)
        else valueError("stall", 32'(expStall), 32'($sampled(stall)));
    assert property (@(posedge clk) disable iff (!nrst) ctrlOf(issued) == ctrlOf(expIssued))
        else valueError("class/aluFn/we/rd", ctrlOf(expIssued), ctrlOf($sampled(issued)));
    assert property (@(posedge clk) disable iff (!nrst) flagsOf(issued) == flagsOf(expIssued))
        else valueError("control flags", flagsOf(expIssued), flagsOf($sampled(issued)));
    assert property (@(posedge clk) disable iff (!nrst) issued.bImm == expIssued.bImm)
        else valueError("bImm", expIssued.bImm, $sampled(issued.bImm));
    assert property (@(posedge clk) disable iff (!nrst) issued.jImm == expIssued.jImm)
        else valueError("jImm", expIssued.jImm, $sampled(issued.jImm));
    assert property (@(posedge clk) disable iff (!nrst) issued.sImm == expIssued.sImm)
        else valueError("sImm", expIssued.sImm, $sampled(issued.sImm));
    assert property (@(posedge clk) disable iff (!nrst) issued.uImm == expIssued.uImm)
        else valueError("uImm", expIssued.uImm, $sampled(issued.uImm));
    assert property (@(posedge clk) disable iff (!nrst) issued.pc == expIssued.pc)
        else valueError("pc", expIssued.pc, $sampled(issued.pc));
    assert property (@(posedge clk) disable iff (!nrst) !checkA || issued.opA == expIssued.opA)
        else valueError("opA", expIssued.opA, $sampled(issued.opA));
    assert property (@(posedge clk) disable iff (!nrst) issued.opB == expIssued.opB)
        else valueError("opB", expIssued.opB, $sampled(issued.opB));

    initial
    begin
        wbPort_t     w;
        opClass_t    cls;
        logic [31:0] ins;
        void'($urandom(32'h8ba27fbc));
        nrst        = 1'b0;
        instr       = NOP_INSTR;
        pc          = 32'd0;
        wb          = '0;
        pending     = 32'd0;
        curPc       = 32'h0000_0100;   // nonzero so a bubble pc stands out
        expIssued   = '0;
        nextIssued  = '0;
        expStall    = 1'b0;
        checkA      = 1'b1;
        checkANext  = 1'b1;
        errors      = 0;
        issuedCount = 0;
        stallCount  = 0;
        testName    = "reset";
        for (int r = 0; r < 32; r++)
            refRegs[r] = 32'd0;
        repeat (16) @(posedge clk);

        testName = "preload";   // x0 written too, it must stay zero
        for (int r = 0; r < 32; r++)
        begin
            w.we   = 1'b1;
            w.addr = 5'(r);
            w.data = $urandom;
            stepCycle(NOP_INSTR, opImm, w);
        end

        // every result commits on the next cycle, so reads hit the bypass often
        testName = "random";
        w = '0;
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            cls = legalClass[$urandom_range(8)];
            ins = makeInstr(cls);
            stepCycle(ins, cls, w);
            w.we   = !(cls inside {opStore, opBranch});
            w.addr = ins[11:7];
            w.data = $urandom;
        end
        stepCycle(NOP_INSTR, opImm, w);

        testName = "stall";
        for (int k = 0; k < 3; k++)
        begin
            stepCycle(withRegs(makeInstr(opImm), 5'd5, 5'd1, 5'd0), opImm, '0);   // x5 in flight
            cls = consumer[k];
            ins = withRegs(makeInstr(cls), 5'd6, (k == 0) ? 5'd5 : 5'd3, (k == 0) ? 5'd2 : 5'd5);
            repeat (2) stepCycle(ins, cls, '0);   // fetch holds
            w.we   = 1'b1;
            w.addr = 5'd5;
            w.data = $urandom;
            stepCycle(ins, cls, w);
            w.addr = 5'd6;
            w.we   = (cls == opReg);
            stepCycle(NOP_INSTR, opImm, w);
        end

        testName = "noFalseStall";
        stepCycle(withRegs(makeInstr(opImm), 5'd9, 5'd0, 5'd0), opImm, '0);
        foreach (quiet[q])
            stepCycle(withRegs(makeInstr(quiet[q]), 5'd0, (quiet[q] == opImm) ? 5'd0 : 5'd9, 5'd9),
                      quiet[q], '0);
        stepCycle(withRegs(makeInstr(opReg), 5'd10, 5'd0, 5'd0), opReg, '0);
        w.we   = 1'b1;
        w.addr = 5'd9;
        w.data = $urandom;
        stepCycle(NOP_INSTR, opImm, w);
        w.addr = 5'd10;
        stepCycle(NOP_INSTR, opImm, w);
        @(posedge clk);
        @(negedge clk);

        $display("summary: %0d issued, %0d stall cycles, %0d errors",
                 issuedCount, stallCount, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
rtl/issuePkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/hazardScoreboard.sv
rtl/issueStage.sv
rtl/issueTop.sv
sim/issueTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= issueTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
